/* rv32i_pipeline.f */
src/rv32i_pkg.sv
src/reg_file.sv
src/pipe_control.sv
src/decode_stage.sv
src/execute_stage.sv
src/rv32i_pipeline.sv
sim/tb_rv32i_pipeline.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the rv32i_pipeline testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_rv32i_pipeline \
    -f rv32i_pipeline.f \
    -o sim_rv32i

./obj_dir/sim_rv32i | tee sim.log

if grep -q "TEST PASSED" sim.log; then
    exit 0
else
    exit 1
fi

/* sim/tb_rv32i_pipeline.sv */
`timescale 1ns/10ps

module tb_rv32i_pipeline import rv32i_pkg::*; ();

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    mem_req_t    imem_req;
    mem_req_t    dmem_req;
    mem_rsp_t    imem_rsp = '0;
    mem_rsp_t    dmem_rsp = '0;
    logic [31:0] rom [64];
    logic [31:0] ram [64];
    // Expected stores in order, {address, data}
    logic [63:0] exp_tab [14];
    // Stores seen at the data port, {address, data}
    logic [63:0] stores [$];
    int          errors = 0;
    int          checked = 0;
    int          imem_wait = 0;
    int          dmem_wait = 0;
    bit          fetch_seen = 1'b0;

    rv32i_pipeline uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .imem_req (imem_req),
        .imem_rsp (imem_rsp),
        .dmem_req (dmem_req),
        .dmem_rsp (dmem_rsp)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    // Instruction encoders
    function automatic logic [31:0] i_type(input logic [6:0] op, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    // sub picks SUB over ADD through funct7 bit 5
    function automatic logic [31:0] r_type(input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic sub);
        return {1'b0, sub, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] s_type(input logic [4:0] rs2, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Memory models for both ports
    always @(negedge clk) begin
        if (!rst_n) begin
            imem_rsp  = '0;
            dmem_rsp  = '0;
            imem_wait = 0;
            dmem_wait = 0;
            compare_word("dmem_req.read", {31'd0, dmem_req.read}, 32'd0);
            compare_word("dmem_req.write", {31'd0, dmem_req.write}, 32'd0);
        end else begin
            // Fetch port never writes and keeps reading once started
            compare_word("imem_req.write", {31'd0, imem_req.write}, 32'd0);
            if (fetch_seen) begin
                compare_word("imem_req.read", {31'd0, imem_req.read}, 32'd1);
            end
            if (imem_req.read && !fetch_seen) begin
                compare_word("imem_req.addr", imem_req.addr, RESET_PC);
                fetch_seen = 1'b1;
            end
            // Fetch port, new latency drawn per request
            imem_rsp.resp = 1'b0;
            if (imem_req.read) begin
                if (imem_wait == 0) begin
                    imem_wait = $urandom_range(4, 1);
                end
                imem_wait--;
                if (imem_wait == 0) begin
                    imem_rsp.resp  = 1'b1;
                    imem_rsp.rdata = rom[imem_req.addr[7:2]];
                end
            end
            // Data port
            dmem_rsp.resp = 1'b0;
            if (dmem_req.read || dmem_req.write) begin
                if (dmem_wait == 0) begin
                    dmem_wait = $urandom_range(4, 1);
                end
                dmem_wait--;
                if (dmem_wait == 0) begin
                    dmem_rsp.resp = 1'b1;
                    if (dmem_req.write) begin
                        ram[dmem_req.addr[7:2]] = dmem_req.wdata;
                        stores.push_back({dmem_req.addr, dmem_req.wdata});
                    end else begin
                        dmem_rsp.rdata = ram[dmem_req.addr[7:2]];
                    end
                end
            end
        end
    end

    initial begin
        logic [63:0] got;
        int          wait_cycles;
        void'($urandom(32'hec29_b18e));
        // Unused ROM words are stores to an address no table entry uses
        for (int i = 0; i < 64; i++) begin
            rom[i] = s_type(5'd0, 5'd10, {4'h4, i[5:0], 2'b00});
            ram[i] = 32'hc0de_0000 | (i << 2);
        end
        // Base pointer, then dependent ALU chains
        rom[0]  = i_type(op_imm, 3'b000, 5'd10, 5'd0, 12'd128);
        rom[1]  = i_type(op_imm, 3'b000, 5'd1, 5'd0, 12'd5);
        rom[2]  = i_type(op_imm, 3'b000, 5'd2, 5'd1, 12'd7);
        rom[3]  = r_type(3'b000, 5'd3, 5'd2, 5'd1, 1'b0);
        rom[4]  = r_type(3'b000, 5'd4, 5'd3, 5'd2, 1'b1);
        rom[5]  = s_type(5'd3, 5'd10, 12'd0);
        rom[6]  = s_type(5'd4, 5'd10, 12'd4);
        rom[7]  = i_type(op_imm, 3'b100, 5'd5, 5'd4, 12'd255);
        rom[8]  = i_type(op_imm, 3'b001, 5'd6, 5'd5, 12'd4);
        rom[9]  = r_type(3'b110, 5'd7, 5'd6, 5'd1, 1'b0);
        rom[10] = s_type(5'd7, 5'd10, 12'd8);
        rom[11] = u_type(5'd8, 20'h12345);
        rom[12] = i_type(op_imm, 3'b101, 5'd9, 5'd8, 12'd12);
        rom[13] = s_type(5'd9, 5'd10, 12'd12);
        rom[14] = i_type(op_imm, 3'b000, 5'd11, 5'd0, 12'hffd);
        rom[15] = r_type(3'b010, 5'd12, 5'd11, 5'd1, 1'b0);
        rom[16] = i_type(op_imm, 3'b010, 5'd13, 5'd11, 12'hffe);
        rom[17] = r_type(3'b000, 5'd13, 5'd13, 5'd12, 1'b0);
        rom[18] = i_type(op_imm, 3'b111, 5'd14, 5'd7, 12'h0f0);
        rom[19] = i_type(op_imm, 3'b110, 5'd14, 5'd14, 12'd3);
        rom[20] = r_type(3'b111, 5'd15, 5'd14, 5'd5, 1'b0);
        rom[21] = s_type(5'd13, 5'd10, 12'd16);
        rom[22] = s_type(5'd15, 5'd10, 12'd20);
        // Load-use pairs
        rom[23] = i_type(op_load, 3'b010, 5'd16, 5'd0, 12'd16);
        rom[24] = i_type(op_imm, 3'b000, 5'd17, 5'd16, 12'd1);
        rom[25] = s_type(5'd17, 5'd10, 12'd24);
        rom[26] = i_type(op_load, 3'b010, 5'd18, 5'd10, 12'd0);
        rom[27] = r_type(3'b000, 5'd19, 5'd18, 5'd18, 1'b0);
        rom[28] = s_type(5'd19, 5'd10, 12'd28);
        // Taken branches jump over two trap stores
        rom[29] = b_type(3'b000, 5'd1, 5'd4, 13'd12);
        rom[32] = b_type(3'b001, 5'd1, 5'd4, 13'd8);
        rom[33] = s_type(5'd1, 5'd10, 12'd32);
        rom[34] = b_type(3'b100, 5'd11, 5'd1, 13'd12);
        rom[37] = b_type(3'b101, 5'd11, 5'd1, 13'd8);
        rom[38] = s_type(5'd2, 5'd10, 12'd36);
        rom[39] = b_type(3'b101, 5'd1, 5'd11, 13'd12);
        rom[42] = b_type(3'b001, 5'd1, 5'd2, 13'd12);
        rom[45] = b_type(3'b000, 5'd1, 5'd2, 13'd8);
        rom[46] = s_type(5'd3, 5'd10, 12'd40);
        rom[47] = b_type(3'b100, 5'd1, 5'd11, 13'd8);
        rom[48] = s_type(5'd5, 5'd10, 12'd44);
        // JAL, then JALR to an odd address
        rom[49] = j_type(5'd20, 21'd12);
        rom[52] = s_type(5'd20, 5'd10, 12'd48);
        rom[53] = i_type(op_imm, 3'b000, 5'd21, 5'd0, 12'd229);
        rom[54] = i_type(op_jalr, 3'b000, 5'd22, 5'd21, 12'd0);
        rom[57] = s_type(5'd22, 5'd10, 12'd52);
        rom[58] = j_type(5'd0, 21'd0);
        exp_tab[0]  = {32'h80, 32'h11};
        exp_tab[1]  = {32'h84, 32'h5};
        exp_tab[2]  = {32'h88, 32'hfa5};
        exp_tab[3]  = {32'h8c, 32'h12345};
        exp_tab[4]  = {32'h90, 32'h2};
        exp_tab[5]  = {32'h94, 32'ha2};
        exp_tab[6]  = {32'h98, 32'hc0de_0011};
        exp_tab[7]  = {32'h9c, 32'h22};
        exp_tab[8]  = {32'ha0, 32'h5};
        exp_tab[9]  = {32'ha4, 32'hc};
        exp_tab[10] = {32'ha8, 32'h11};
        exp_tab[11] = {32'hac, 32'hfa};
        exp_tab[12] = {32'hb0, 32'hc8};
        exp_tab[13] = {32'hb4, 32'hdc};

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n <= 1'b1;

        for (int k = 0; k < $size(exp_tab); k++) begin
            wait_cycles = 0;
            while (stores.size() == 0 && wait_cycles < 400) begin
                @(posedge clk);
                wait_cycles++;
            end
            if (stores.size() == 0) begin
                errors++;
                $display("Timeout: store %0d to address %h never arrived", k, exp_tab[k][63:32]);
                break;
            end
            got = stores.pop_front();
            compare_word("dmem_req.addr", got[63:32], exp_tab[k][63:32]);
            compare_word("dmem_req.wdata", got[31:0], exp_tab[k][31:0]);
            checked++;
        end

        // Program spins on its self-jump and must not store again
        wait_cycles = 0;
        while (stores.size() == 0 && wait_cycles < 200) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (stores.size() != 0) begin
            errors++;
            $display("Unexpected extra store to address %h", stores[0][63:32]);
        end

        $display("Checked %0d of %0d stores, %0d errors", checked, $size(exp_tab), errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* src/rv32i_pipeline.sv */
`timescale 1ns/10ps

module rv32i_pipeline import rv32i_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    output mem_req_t imem_req,
    input  mem_rsp_t imem_rsp,
    output mem_req_t dmem_req,
    input  mem_rsp_t dmem_rsp
);

    logic [XLEN-1:0] pc;
    logic            fetch_en;
    pipe_pkt_t       if_id;
    pipe_pkt_t       id_ex;
    pipe_pkt_t       ex_mem;
    pipe_pkt_t       mem_wb;
    pipe_pkt_t       fetch_pkt;
    pipe_pkt_t       dec_pkt;
    pipe_pkt_t       ex_pkt;
    logic            advance;
    logic            load_pc;
    logic            br_taken;
    logic            dmem_read;
    logic            dmem_write;
    buf_sel_e        if_id_sel;
    buf_sel_e        id_ex_sel;
    pc_sel_e         pc_sel;
    logic [XLEN-1:0] target;
    logic            dmem_done;
    logic [XLEN-1:0] dmem_rdata;
    logic [XLEN-1:0] load_data;
    logic            wb_en;

    // Next buffer contents; a bubble carries a NOP word and no valid bit
    function automatic pipe_pkt_t buf_next(
        input buf_sel_e  sel,
        input pipe_pkt_t cur,
        input pipe_pkt_t nxt
    );
        pipe_pkt_t pkt;
        case (sel)
            buf_load: pkt = nxt;
            buf_hold: pkt = cur;
            default: begin
                pkt        = '0;
                pkt.opcode = op_imm;
                pkt.result = NOP_INSTR;
            end
        endcase
        return pkt;
    endfunction

    // Raw register fields split off at fetch
    always_comb begin
        fetch_pkt        = '0;
        fetch_pkt.valid  = 1'b1;
        fetch_pkt.pc     = pc;
        fetch_pkt.opcode = opcode_e'(imem_rsp.rdata[6:0]);
        fetch_pkt.rd     = imem_rsp.rdata[11:7];
        fetch_pkt.funct3 = imem_rsp.rdata[14:12];
        fetch_pkt.rs1    = imem_rsp.rdata[19:15];
        fetch_pkt.rs2    = imem_rsp.rdata[24:20];
        fetch_pkt.result = imem_rsp.rdata;
    end

    pipe_control u_pipe_control (
        .clk        (clk),
        .rst_n      (rst_n),
        .if_id      (if_id),
        .id_ex      (id_ex),
        .ex_mem     (ex_mem),
        .br_taken   (br_taken),
        .imem_resp  (imem_rsp.resp),
        .dmem_resp  (dmem_rsp.resp || dmem_done),
        .advance    (advance),
        .load_pc    (load_pc),
        .if_id_sel  (if_id_sel),
        .id_ex_sel  (id_ex_sel),
        .pc_sel     (pc_sel),
        .dmem_read  (dmem_read),
        .dmem_write (dmem_write)
    );

    decode_stage u_decode_stage (
        .clk     (clk),
        .rst_n   (rst_n),
        .if_id   (if_id),
        .wb_en   (wb_en),
        .wb_rd   (mem_wb.rd),
        .wb_data (mem_wb.result),
        .dec_pkt (dec_pkt)
    );

    execute_stage u_execute_stage (
        .id_ex    (id_ex),
        .ex_mem   (ex_mem),
        .mem_wb   (mem_wb),
        .ex_pkt   (ex_pkt),
        .br_taken (br_taken),
        .target   (target)
    );

    // PC and fetch enable
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc       <= RESET_PC;
            fetch_en <= 1'b0;
        end else begin
            fetch_en <= 1'b1;
            if (load_pc) begin
                pc <= (pc_sel == pc_target) ? target : pc + 32'd4;
            end
        end
    end

    // Pipeline buffers, all frozen without advance
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            if_id  <= buf_next(buf_bubble, if_id, fetch_pkt);
            id_ex  <= buf_next(buf_bubble, id_ex, dec_pkt);
            ex_mem <= buf_next(buf_bubble, ex_mem, ex_pkt);
            mem_wb <= buf_next(buf_bubble, mem_wb, ex_mem);
        end else if (advance) begin
            if_id  <= buf_next(if_id_sel, if_id, fetch_pkt);
            id_ex  <= buf_next(id_ex_sel, id_ex, dec_pkt);
            ex_mem <= ex_pkt;
            mem_wb <= ex_mem;
            // Load data replaces the address
            if (ex_mem.ctrl.mem_read) begin
                mem_wb.result <= load_data;
            end
        end
    end

    // Data response can land while fetch is still pending
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dmem_done <= 1'b0;
        end else if (advance) begin
            dmem_done <= 1'b0;
        end else if (dmem_rsp.resp) begin
            dmem_done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (dmem_rsp.resp) begin
            dmem_rdata <= dmem_rsp.rdata;
        end
    end

    assign load_data = dmem_done ? dmem_rdata : dmem_rsp.rdata;

    // Drop the strobe after resp so a store is not repeated
    assign dmem_req = '{read:  dmem_read && !dmem_done,
                        write: dmem_write && !dmem_done,
                        addr:  ex_mem.result,
                        wdata: ex_mem.rs2_val};

    assign imem_req = '{read: fetch_en, write: 1'b0, addr: pc, wdata: '0};

    // Writeback enable
    assign wb_en = mem_wb.valid && mem_wb.ctrl.reg_write;

endmodule

/* src/execute_stage.sv */
`timescale 1ns/10ps

module execute_stage import rv32i_pkg::*; (
    input  pipe_pkt_t       id_ex,
    input  pipe_pkt_t       ex_mem,
    input  pipe_pkt_t       mem_wb,
    output pipe_pkt_t       ex_pkt,
    output logic            br_taken,
    output logic [XLEN-1:0] target
);

    logic [XLEN-1:0] fwd_a;
    logic [XLEN-1:0] fwd_b;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_out;
    logic [XLEN-1:0] jalr_sum;
    logic            cond;

    // Operand source: EX/MEM first, then MEM/WB, then register file
    function automatic logic [XLEN-1:0] fwd_sel(
        input logic [4:0]      rs,
        input logic [XLEN-1:0] rf_val,
        input pipe_pkt_t       em,
        input pipe_pkt_t       mw
    );
        logic [XLEN-1:0] val;
        val = rf_val;
        if (mw.valid && mw.ctrl.reg_write && mw.rd != 5'd0 && mw.rd == rs) begin
            val = mw.result;
        end
        // younger producer overrides
        if (em.valid && em.ctrl.reg_write && em.rd != 5'd0 && em.rd == rs) begin
            val = em.result;
        end
        return val;
    endfunction

    assign fwd_a = fwd_sel(id_ex.rs1, id_ex.rs1_val, ex_mem, mem_wb);
    assign fwd_b = fwd_sel(id_ex.rs2, id_ex.rs2_val, ex_mem, mem_wb);
    assign op_b  = id_ex.ctrl.use_imm ? id_ex.imm : fwd_b;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            alu_add:    alu_out = fwd_a + op_b;
            alu_sub:    alu_out = fwd_a - op_b;
            alu_and:    alu_out = fwd_a & op_b;
            alu_or:     alu_out = fwd_a | op_b;
            alu_xor:    alu_out = fwd_a ^ op_b;
            alu_slt:    alu_out = {{(XLEN-1){1'b0}}, $signed(fwd_a) < $signed(op_b)};
            alu_sll:    alu_out = fwd_a << op_b[4:0];
            alu_srl:    alu_out = fwd_a >> op_b[4:0];
            alu_pass_b: alu_out = op_b;
            default:    alu_out = '0;
        endcase
    end

    // Branch compare on forwarded registers
    always_comb begin
        case (id_ex.funct3)
            3'b000:  cond = (fwd_a == fwd_b);
            3'b001:  cond = (fwd_a != fwd_b);
            3'b100:  cond = ($signed(fwd_a) < $signed(fwd_b));
            3'b101:  cond = ($signed(fwd_a) >= $signed(fwd_b));
            default: cond = 1'b0;
        endcase
    end

    assign br_taken = id_ex.valid && id_ex.ctrl.is_branch && cond;

    // JALR drops bit 0, others are PC relative
    assign jalr_sum = fwd_a + id_ex.imm;
    assign target   = (id_ex.opcode == op_jalr) ? {jalr_sum[XLEN-1:1], 1'b0}
                                                : id_ex.pc + id_ex.imm;

    always_comb begin
        ex_pkt         = id_ex;
        ex_pkt.rs1_val = fwd_a;
        // Store data leaves with the forwarded value
        ex_pkt.rs2_val = fwd_b;
        ex_pkt.result  = id_ex.ctrl.link ? id_ex.pc + 32'd4 : alu_out;
    end

endmodule

/* src/decode_stage.sv */
`timescale 1ns/10ps

module decode_stage import rv32i_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  pipe_pkt_t       if_id,
    input  logic            wb_en,
    input  logic [4:0]      wb_rd,
    input  logic [XLEN-1:0] wb_data,
    output pipe_pkt_t       dec_pkt
);

    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    alu_op_e         alu_f3;
    logic            f3_ok;

    // Raw word rides in the IF/ID result field
    assign instr = if_id.result;

    reg_file u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs1     (if_id.rs1),
        .rs2     (if_id.rs2),
        .wr_en   (wb_en),
        .rd      (wb_rd),
        .wr_data (wb_data),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val)
    );

    // funct3 to ALU function, shared by OP and OP-IMM
    always_comb begin
        f3_ok = 1'b1;
        case (if_id.funct3)
            3'b000: alu_f3 = alu_add;
            3'b001: alu_f3 = alu_sll;
            3'b010: alu_f3 = alu_slt;
            3'b100: alu_f3 = alu_xor;
            3'b101: alu_f3 = alu_srl;
            3'b110: alu_f3 = alu_or;
            3'b111: alu_f3 = alu_and;
            default: begin
                // SLTU not supported
                alu_f3 = alu_add;
                f3_ok  = 1'b0;
            end
        endcase
    end

    always_comb begin
        dec_pkt         = if_id;
        dec_pkt.rs1_val = rs1_val;
        dec_pkt.rs2_val = rs2_val;
        dec_pkt.imm     = '0;
        dec_pkt.result  = '0;
        dec_pkt.ctrl    = '0;
        case (if_id.opcode)
            op_lui: begin
                dec_pkt.imm            = {instr[31:12], 12'b0};
                dec_pkt.ctrl.alu_op    = alu_pass_b;
                dec_pkt.ctrl.use_imm   = 1'b1;
                dec_pkt.ctrl.reg_write = 1'b1;
            end
            op_imm: begin
                dec_pkt.imm            = {{20{instr[31]}}, instr[31:20]};
                dec_pkt.ctrl.alu_op    = alu_f3;
                dec_pkt.ctrl.use_imm   = 1'b1;
                dec_pkt.ctrl.reg_write = 1'b1;
                dec_pkt.valid          = if_id.valid && f3_ok;
            end
            op_reg: begin
                // funct7 bit 30 picks SUB
                dec_pkt.ctrl.alu_op    = (if_id.funct3 == 3'b000 && instr[30]) ? alu_sub : alu_f3;
                dec_pkt.ctrl.reg_write = 1'b1;
                dec_pkt.valid          = if_id.valid && f3_ok;
            end
            op_load: begin
                dec_pkt.imm            = {{20{instr[31]}}, instr[31:20]};
                dec_pkt.ctrl.alu_op    = alu_add;
                dec_pkt.ctrl.use_imm   = 1'b1;
                dec_pkt.ctrl.reg_write = 1'b1;
                dec_pkt.ctrl.mem_read  = 1'b1;
            end
            op_store: begin
                dec_pkt.imm            = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                dec_pkt.ctrl.alu_op    = alu_add;
                dec_pkt.ctrl.use_imm   = 1'b1;
                dec_pkt.ctrl.mem_write = 1'b1;
            end
            op_br: begin
                dec_pkt.imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                               instr[11:8], 1'b0};
                dec_pkt.ctrl.is_branch = 1'b1;
                // Only BEQ, BNE, BLT, BGE
                dec_pkt.valid = if_id.valid && !if_id.funct3[1];
            end
            op_jal: begin
                dec_pkt.imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                               instr[30:21], 1'b0};
                dec_pkt.ctrl.is_jump   = 1'b1;
                dec_pkt.ctrl.link      = 1'b1;
                dec_pkt.ctrl.reg_write = 1'b1;
            end
            op_jalr: begin
                dec_pkt.imm            = {{20{instr[31]}}, instr[31:20]};
                dec_pkt.ctrl.use_imm   = 1'b1;
                dec_pkt.ctrl.is_jump   = 1'b1;
                dec_pkt.ctrl.link      = 1'b1;
                dec_pkt.ctrl.reg_write = 1'b1;
            end
            // unknown opcode turns into a bubble
            default: dec_pkt.valid = 1'b0;
        endcase
    end

endmodule

/* src/pipe_control.sv */
`timescale 1ns/10ps

module pipe_control import rv32i_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  pipe_pkt_t if_id,
    input  pipe_pkt_t id_ex,
    input  pipe_pkt_t ex_mem,
    input  logic      br_taken,
    input  logic      imem_resp,
    input  logic      dmem_resp,
    output logic      advance,
    output logic      load_pc,
    output buf_sel_e  if_id_sel,
    output buf_sel_e  id_ex_sel,
    output pc_sel_e   pc_sel,
    output logic      dmem_read,
    output logic      dmem_write
);

    logic redirect;
    logic load_use;
    logic rs1_hit;
    logic rs2_hit;

    // Data strobes only for a live memory op in MEM
    assign dmem_read  = ex_mem.valid && ex_mem.ctrl.mem_read;
    assign dmem_write = ex_mem.valid && ex_mem.ctrl.mem_write;

    // Move everything once fetch is back and data port is idle or done
    assign advance = imem_resp && (!(dmem_read || dmem_write) || dmem_resp);

    // Raw source fields straight from IF/ID
    assign rs1_hit = (if_id.rs1 != 5'd0) && (if_id.rs1 == id_ex.rd);
    assign rs2_hit = (if_id.rs2 != 5'd0) && (if_id.rs2 == id_ex.rd);

    // Load in EX feeding the instruction in ID
    assign load_use = id_ex.valid && id_ex.ctrl.mem_read && (id_ex.rd != 5'd0)
                      && (rs1_hit || rs2_hit);

    // Jumps always redirect, branches only when taken
    assign redirect = (id_ex.valid && id_ex.ctrl.is_jump) || br_taken;

    always_comb begin
        pc_sel    = pc_plus4;
        if_id_sel = buf_load;
        id_ex_sel = buf_load;
        if (redirect) begin
            // Squash both younger instructions
            pc_sel    = pc_target;
            if_id_sel = buf_bubble;
            id_ex_sel = buf_bubble;
        end else if (load_use) begin
            // Freeze front end, bubble into EX
            pc_sel    = pc_hold;
            if_id_sel = buf_hold;
            id_ex_sel = buf_bubble;
        end
    end

    assign load_pc = advance && (pc_sel != pc_hold);

    // One data access type at a time
    assert property (@(posedge clk) disable iff (!rst_n) !(dmem_read && dmem_write));

    // Squashed or stalled slot reaches EX as a bubble
    assert property (@(posedge clk) disable iff (!rst_n)
        (advance && id_ex_sel == buf_bubble) |=> !id_ex.valid);

endmodule

/* src/reg_file.sv */
`timescale 1ns/10ps

module reg_file import rv32i_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    input  logic            wr_en,
    input  logic [4:0]      rd,
    input  logic [XLEN-1:0] wr_data,
    output logic [XLEN-1:0] rs1_val,
    output logic [XLEN-1:0] rs2_val
);

    // x0 has no storage
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (wr_en && rd != 5'd0) begin
            regs[rd] <= wr_data;
        end
    end

    // Same-cycle writeback bypassed to readers
    assign rs1_val = (rs1 == 5'd0) ? '0 : (wr_en && rd == rs1) ? wr_data : regs[rs1];
    assign rs2_val = (rs2 == 5'd0) ? '0 : (wr_en && rd == rs2) ? wr_data : regs[rs2];

    // Written value reads back next cycle, a write to x0 leaves zero
    assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |=> (rs1 != $past(rd)) || (wr_en && rd == rs1)
                  || (rs1_val == (($past(rd) == 5'd0) ? '0 : $past(wr_data))));

endmodule

/* src/rv32i_pkg.sv */
package rv32i_pkg;

    // Machine word width
    localparam int XLEN = 32;

    // First fetch address out of reset
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // ADDI x0, x0, 0
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_br    = 7'b1100011,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl,
        alu_pass_b
    } alu_op_e;

    // Next PC source
    typedef enum logic [1:0] {
        pc_plus4,
        pc_target,
        pc_hold
    } pc_sel_e;

    // Pipeline buffer load choice
    typedef enum logic [1:0] {
        buf_load,
        buf_hold,
        buf_bubble
    } buf_sel_e;

    // Decoded control bits
    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    is_branch;
        logic    is_jump;
        // Writes PC+4 to rd
        logic    link;
    } ctrl_t;

    // Packet carried through every pipeline buffer
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        opcode_e         opcode;
        logic [2:0]      funct3;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] rs1_val;
        logic [XLEN-1:0] rs2_val;
        // Raw instruction in IF/ID, stage result afterwards
        logic [XLEN-1:0] result;
        ctrl_t           ctrl;
    } pipe_pkt_t;

    // Memory request, same shape for both ports
    typedef struct packed {
        logic            read;
        logic            write;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic            resp;
        logic [XLEN-1:0] rdata;
    } mem_rsp_t;

endpackage
